// ==== hdl/smartnic_pkg.sv ====
package smartnic_pkg;

    // Source identifier. Line port i is i, host port i is 2 + i.
    typedef logic [1:0] port_t;

    // Destination code carried on every beat.
    typedef logic [1:0] igr_tdest_t;

    localparam igr_tdest_t IGR_TDEST_BYPASS = 2'd2;
    localparam igr_tdest_t IGR_TDEST_DROP   = 2'd3;

    // Two ports of each kind at most, limited by the width of port_t.
    localparam int NUM_SRC = 4;

    typedef struct packed {
        logic [511:0] data;
        logic [63:0]  keep;
        logic         last;
        port_t        tid;
        igr_tdest_t   tdest;
    } axis_beat_t;

    // Register map, in word addresses.
    localparam logic [2:0] REG_ADDR_TDEST_BASE    = 3'd0;
    localparam logic [2:0] REG_ADDR_SWITCH_CONFIG = 3'd4;

    typedef struct packed {
        logic [1:0] reserved;
        logic       igr_sw_tpause;
    } switch_config_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    function automatic port_t line_src_id(input int idx);
        return port_t'(idx);
    endfunction

    function automatic port_t host_src_id(input int idx);
        return port_t'(2 + idx);
    endfunction

endpackage

// ==== hdl/axis_pipe.sv ====
module axis_pipe #(
    parameter type payload_t = smartnic_pkg::axis_beat_t
) (
    input  logic     core_clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     skid_valid;
    payload_t skid_payload;
    logic     in_xfer;

    // Ready is the inverse of a register, so it never depends on out_ready.
    assign in_ready = !skid_valid;
    assign in_xfer  = in_valid && in_ready;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_ready || !out_valid) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (out_ready || !out_valid) begin
            out_payload <= skid_valid ? skid_payload : in_payload;
        end else if (in_xfer) begin
            // Output is stalled, so the incoming beat waits in the skid entry.
            skid_payload <= in_payload;
        end
    end

    payload_stable_a : assert property (
        @(posedge core_clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_payload)
    );

endmodule

// ==== hdl/igr_tdest_tag.sv ====
module igr_tdest_tag #(
    parameter smartnic_pkg::port_t SRC_ID = '0
) (
    input  logic                     core_clk,
    input  logic                     reset,
    input  smartnic_pkg::igr_tdest_t cfg_tdest,
    input  logic                     src_valid,
    output logic                     src_ready,
    input  smartnic_pkg::axis_beat_t src_beat,
    output logic                     tag_valid,
    input  logic                     tag_ready,
    output smartnic_pkg::axis_beat_t tag_beat
);

    logic                     in_pkt;
    logic                     src_xfer;
    smartnic_pkg::igr_tdest_t pkt_tdest;
    smartnic_pkg::axis_beat_t stamped_beat;

    assign src_xfer = src_valid && src_ready;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (src_xfer) begin
            in_pkt <= !src_beat.last;
        end
    end

    // The code is sampled only at start of packet and held until the end.
    always_ff @(posedge core_clk) begin
        if (src_xfer && !in_pkt) begin
            pkt_tdest <= cfg_tdest;
        end
    end

    always_comb begin
        stamped_beat       = src_beat;
        stamped_beat.tid   = SRC_ID;
        stamped_beat.tdest = in_pkt ? pkt_tdest : cfg_tdest;
    end

    axis_pipe #(
        .payload_t (smartnic_pkg::axis_beat_t)
    ) tag_pipe (
        .core_clk    (core_clk),
        .reset       (reset),
        .in_valid    (src_valid),
        .in_ready    (src_ready),
        .in_payload  (stamped_beat),
        .out_valid   (tag_valid),
        .out_ready   (tag_ready),
        .out_payload (tag_beat)
    );

endmodule

// ==== hdl/axis_pkt_arbiter.sv ====
module axis_pkt_arbiter #(
    parameter int N = 2
) (
    input  logic                     core_clk,
    input  logic                     reset,
    input  logic                     in_valid [N],
    output logic                     in_ready [N],
    input  smartnic_pkg::axis_beat_t in_beat  [N],
    output logic                     out_valid,
    input  logic                     out_ready,
    output smartnic_pkg::axis_beat_t out_beat
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0]         grant_q;
    logic [IDX_W-1:0]         sel;
    logic                     locked_q;
    logic                     pipe_valid;
    logic                     pipe_ready;
    logic                     xfer;
    logic                     xfer_last;
    smartnic_pkg::axis_beat_t pipe_beat;

    // Round robin: the lowest offset after the last grant wins.
    always_comb begin
        sel = grant_q;
        if (!locked_q) begin
            for (int off = N; off >= 1; off--) begin
                if (in_valid[(int'(grant_q) + off) % N]) begin
                    sel = IDX_W'((int'(grant_q) + off) % N);
                end
            end
        end
    end

    assign pipe_valid = in_valid[sel];
    assign pipe_beat  = in_beat[sel];
    assign xfer       = pipe_valid && pipe_ready;
    assign xfer_last  = pipe_beat.last;

    always_comb begin
        for (int k = 0; k < N; k++) begin
            in_ready[k] = pipe_ready && (sel == IDX_W'(k));
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            grant_q  <= IDX_W'(N - 1);
            locked_q <= 1'b0;
        end else if (xfer) begin
            grant_q  <= sel;
            locked_q <= !xfer_last;
        end
    end

    axis_pipe #(
        .payload_t (smartnic_pkg::axis_beat_t)
    ) out_pipe (
        .core_clk    (core_clk),
        .reset       (reset),
        .in_valid    (pipe_valid),
        .in_ready    (pipe_ready),
        .in_payload  (pipe_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_payload (out_beat)
    );

    // A beat that is not the last one keeps the same input selected.
    grant_locked_a : assert property (
        @(posedge core_clk) disable iff (reset)
        xfer && !xfer_last |=> sel == $past(sel)
    );

endmodule

// ==== hdl/igr_path_demux.sv ====
module igr_path_demux (
    input  logic                     core_clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  smartnic_pkg::axis_beat_t in_beat,
    output logic                     app_valid,
    input  logic                     app_ready,
    output smartnic_pkg::axis_beat_t app_beat,
    output logic                     byp_valid,
    input  logic                     byp_ready,
    output smartnic_pkg::axis_beat_t byp_beat
);

    logic                     is_drop;
    logic                     is_byp;
    logic                     app_in_ready;
    smartnic_pkg::axis_beat_t app_in_beat;

    assign is_drop = (in_beat.tdest == smartnic_pkg::IGR_TDEST_DROP);
    assign is_byp  = (in_beat.tdest == smartnic_pkg::IGR_TDEST_BYPASS);

    // Bypass waits until the application stage has drained.
    assign byp_valid = in_valid && is_byp && !app_valid;
    assign byp_beat  = in_beat;

    always_comb begin
        if (is_drop) begin
            in_ready = 1'b1;
        end else if (is_byp) begin
            in_ready = byp_ready && !app_valid;
        end else begin
            in_ready = app_in_ready;
        end
    end

    always_comb begin
        app_in_beat       = in_beat;
        app_in_beat.tdest = smartnic_pkg::igr_tdest_t'({1'b0, in_beat.tid[0]});
    end

    axis_pipe #(
        .payload_t (smartnic_pkg::axis_beat_t)
    ) app_pipe (
        .core_clk    (core_clk),
        .reset       (reset),
        .in_valid    (in_valid && !is_drop && !is_byp),
        .in_ready    (app_in_ready),
        .in_payload  (app_in_beat),
        .out_valid   (app_valid),
        .out_ready   (app_ready),
        .out_payload (app_beat)
    );

    one_leg_a : assert property (
        @(posedge core_clk) disable iff (reset)
        !(app_valid && byp_valid)
    );

endmodule

// ==== hdl/smartnic_sw_regs.sv ====
module smartnic_sw_regs (
    input  logic                                                  core_clk,
    input  logic                                                  reset,
    input  smartnic_pkg::wb_req_t                                 wb_req,
    output smartnic_pkg::wb_rsp_t                                 wb_rsp,
    output smartnic_pkg::igr_tdest_t [smartnic_pkg::NUM_SRC-1:0] igr_sw_tdest,
    output smartnic_pkg::switch_config_t                          switch_config
);

    localparam int CFG_W = $bits(smartnic_pkg::switch_config_t);

    logic        access;
    logic        is_tdest;
    logic        is_config;
    logic [1:0]  tdest_idx;
    logic [31:0] rd_data;

    // Ack is raised the cycle after cyc and stb first appear.
    assign access    = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign is_tdest  = wb_req.adr < 3'(smartnic_pkg::REG_ADDR_TDEST_BASE + smartnic_pkg::NUM_SRC);
    assign is_config = wb_req.adr == smartnic_pkg::REG_ADDR_SWITCH_CONFIG;
    assign tdest_idx = 2'(wb_req.adr - smartnic_pkg::REG_ADDR_TDEST_BASE);

    always_comb begin
        rd_data = '0;
        if (is_tdest) begin
            rd_data[1:0] = igr_sw_tdest[tdest_idx];
        end else if (is_config) begin
            rd_data[CFG_W-1:0] = switch_config;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            wb_rsp.ack <= 1'b0;
        end else begin
            wb_rsp.ack <= access;
        end
    end

    always_ff @(posedge core_clk) begin
        if (access) begin
            wb_rsp.dat_r <= rd_data;
        end
    end

    // Writes land at the end of the ack cycle.
    always_ff @(posedge core_clk) begin
        if (reset) begin
            igr_sw_tdest  <= '0;
            switch_config <= '0;
        end else if (wb_rsp.ack && wb_req.we) begin
            if (is_tdest) begin
                igr_sw_tdest[tdest_idx] <= wb_req.dat_w[1:0];
            end else if (is_config) begin
                switch_config <= smartnic_pkg::switch_config_t'(wb_req.dat_w[CFG_W-1:0]);
            end
        end
    end

    ack_in_cycle_a : assert property (
        @(posedge core_clk) disable iff (reset)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb
    );

endmodule

// ==== hdl/smartnic_igr_switch.sv ====
module smartnic_igr_switch #(
    parameter int NUM_CMAC = 2
) (
    input  logic                     core_clk,
    input  logic                     reset,
    input  smartnic_pkg::wb_req_t    wb_req,
    output smartnic_pkg::wb_rsp_t    wb_rsp,

    input  logic                     cmac_valid [NUM_CMAC],
    output logic                     cmac_ready [NUM_CMAC],
    input  smartnic_pkg::axis_beat_t cmac_beat  [NUM_CMAC],

    input  logic                     host_valid [NUM_CMAC],
    output logic                     host_ready [NUM_CMAC],
    input  smartnic_pkg::axis_beat_t host_beat  [NUM_CMAC],

    output logic                     app_valid  [NUM_CMAC],
    input  logic                     app_ready  [NUM_CMAC],
    output smartnic_pkg::axis_beat_t app_beat   [NUM_CMAC],

    output logic                     byp_valid,
    input  logic                     byp_ready,
    output smartnic_pkg::axis_beat_t byp_beat
);

    smartnic_pkg::igr_tdest_t [smartnic_pkg::NUM_SRC-1:0] igr_sw_tdest;
    smartnic_pkg::switch_config_t                          switch_config;

    // Index 0 of the second dimension is the line port, 1 the host port.
    logic                     tag_valid [NUM_CMAC][2];
    logic                     tag_ready [NUM_CMAC][2];
    smartnic_pkg::axis_beat_t tag_beat  [NUM_CMAC][2];

    logic                     mux_valid [NUM_CMAC];
    logic                     mux_ready [NUM_CMAC];
    smartnic_pkg::axis_beat_t mux_beat  [NUM_CMAC];

    logic                     leg_valid [NUM_CMAC];
    logic                     leg_ready [NUM_CMAC];
    smartnic_pkg::axis_beat_t leg_beat  [NUM_CMAC];

    logic                     bq_valid  [NUM_CMAC];
    logic                     bq_ready  [NUM_CMAC];
    smartnic_pkg::axis_beat_t bq_beat   [NUM_CMAC];

    logic                     byp_arb_valid;
    logic                     byp_arb_ready;

    smartnic_sw_regs regs_i (
        .core_clk      (core_clk),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .igr_sw_tdest  (igr_sw_tdest),
        .switch_config (switch_config)
    );

    for (genvar i = 0; i < NUM_CMAC; i++) begin : g_port
        igr_tdest_tag #(.SRC_ID(smartnic_pkg::line_src_id(i))) cmac_tag_i (
            .core_clk (core_clk), .reset (reset),
            .cfg_tdest (igr_sw_tdest[smartnic_pkg::line_src_id(i)]),
            .src_valid (cmac_valid[i]), .src_ready (cmac_ready[i]), .src_beat (cmac_beat[i]),
            .tag_valid (tag_valid[i][0]), .tag_ready (tag_ready[i][0]), .tag_beat (tag_beat[i][0])
        );

        igr_tdest_tag #(.SRC_ID(smartnic_pkg::host_src_id(i))) host_tag_i (
            .core_clk (core_clk), .reset (reset),
            .cfg_tdest (igr_sw_tdest[smartnic_pkg::host_src_id(i)]),
            .src_valid (host_valid[i]), .src_ready (host_ready[i]), .src_beat (host_beat[i]),
            .tag_valid (tag_valid[i][1]), .tag_ready (tag_ready[i][1]), .tag_beat (tag_beat[i][1])
        );

        axis_pkt_arbiter #(.N(2)) port_arb_i (
            .core_clk (core_clk), .reset (reset),
            .in_valid (tag_valid[i]), .in_ready (tag_ready[i]), .in_beat (tag_beat[i]),
            .out_valid (mux_valid[i]), .out_ready (mux_ready[i]), .out_beat (mux_beat[i])
        );

        igr_path_demux demux_i (
            .core_clk (core_clk), .reset (reset),
            .in_valid (mux_valid[i]), .in_ready (mux_ready[i]), .in_beat (mux_beat[i]),
            .app_valid (app_valid[i]), .app_ready (app_ready[i]), .app_beat (app_beat[i]),
            .byp_valid (leg_valid[i]), .byp_ready (leg_ready[i]), .byp_beat (leg_beat[i])
        );

        // Register slice on each bypass leg ahead of the shared arbiter.
        axis_pipe #(.payload_t(smartnic_pkg::axis_beat_t)) byp_leg_pipe_i (
            .core_clk (core_clk), .reset (reset),
            .in_valid (leg_valid[i]), .in_ready (leg_ready[i]), .in_payload (leg_beat[i]),
            .out_valid (bq_valid[i]), .out_ready (bq_ready[i]), .out_payload (bq_beat[i])
        );
    end

    axis_pkt_arbiter #(.N(NUM_CMAC)) byp_arb_i (
        .core_clk (core_clk), .reset (reset),
        .in_valid (bq_valid), .in_ready (bq_ready), .in_beat (bq_beat),
        .out_valid (byp_arb_valid), .out_ready (byp_arb_ready), .out_beat (byp_beat)
    );

    // While paused, bypass beats stay parked in the arbiter and behind it.
    assign byp_valid     = byp_arb_valid && !switch_config.igr_sw_tpause;
    assign byp_arb_ready = byp_ready && !switch_config.igr_sw_tpause;

endmodule

// ==== bench/smartnic_igr_switch_tb.sv ====
module smartnic_igr_switch_tb;

    localparam int NUM_CMAC  = 2;
    localparam int NUM_Q     = 12;
    localparam int DEST_APP  = 0;
    localparam int DEST_BYP  = 1;
    localparam int DEST_NONE = 2;

    typedef struct {
        string                    name;
        int                       src;
        int                       len;
        smartnic_pkg::igr_tdest_t code;
        int                       mid_code;
        bit                       pause;
        int                       dest;
        int                       batch;
    } test_row_t;

    logic                     core_clk;
    logic                     reset;
    smartnic_pkg::wb_req_t    wb_req;
    smartnic_pkg::wb_rsp_t    wb_rsp;
    logic                     cmac_valid [NUM_CMAC];
    logic                     cmac_ready [NUM_CMAC];
    smartnic_pkg::axis_beat_t cmac_beat  [NUM_CMAC];
    logic                     host_valid [NUM_CMAC];
    logic                     host_ready [NUM_CMAC];
    smartnic_pkg::axis_beat_t host_beat  [NUM_CMAC];
    logic                     app_valid  [NUM_CMAC];
    logic                     app_ready  [NUM_CMAC];
    smartnic_pkg::axis_beat_t app_beat   [NUM_CMAC];
    logic                     byp_valid;
    logic                     byp_ready;
    smartnic_pkg::axis_beat_t byp_beat;

    test_row_t                rows [$];
    // Expected beats per output and source, queue index is out * 4 + source.
    smartnic_pkg::axis_beat_t exp_beats [NUM_Q][$];
    int                       exp_rows  [NUM_Q][$];
    int                       row_left  [32];
    int                       row_errs  [32];
    int                       open_src  [3];
    int                       errors       = 0;
    int                       tests_run    = 0;
    int                       tests_failed = 0;
    int                       cycles       = 0;
    int                       limit        = 0;
    int                       seed;
    bit                       paused       = 0;

    smartnic_igr_switch #(
        .NUM_CMAC (NUM_CMAC)
    ) smartnic_igr_switch_i (
        .core_clk   (core_clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .cmac_valid (cmac_valid),
        .cmac_ready (cmac_ready),
        .cmac_beat  (cmac_beat),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .host_beat  (host_beat),
        .app_valid  (app_valid),
        .app_ready  (app_ready),
        .app_beat   (app_beat),
        .byp_valid  (byp_valid),
        .byp_ready  (byp_ready),
        .byp_beat   (byp_beat)
    );

    initial begin
        core_clk = 1'b0;
        forever begin
            #5 core_clk = ~core_clk;
        end
    end

    always @(posedge core_clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run stopped after %0d cycles, traffic did not complete", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Random back-pressure on every output.
    always @(posedge core_clk) begin
        for (int i = 0; i < NUM_CMAC; i++) begin
            app_ready[i] <= ($urandom % 4) != 0;
        end
        byp_ready <= ($urandom % 4) != 0;
    end

    always @(negedge core_clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_CMAC; i++) begin
                if (app_valid[i] && app_ready[i]) begin
                    check_output(i, app_beat[i]);
                end
            end
            if (byp_valid && byp_ready) begin
                check_output(2, byp_beat);
            end
            if (byp_valid && paused) begin
                $display("bypass valid is high while the switch is paused");
                errors++;
            end
        end
    end

    task automatic add_row(input string name, input int src, input int len,
                           input smartnic_pkg::igr_tdest_t code, input int mid_code,
                           input bit pause, input int dest, input int batch);
        rows.push_back('{name, src, len, code, mid_code, pause, dest, batch});
    endtask

    function automatic string out_name(input int out);
        return (out == 2) ? "byp" : $sformatf("app%0d", out);
    endfunction

    task automatic mismatch(input string name, input string field,
                            input logic [511:0] exp, input logic [511:0] act);
        $display("mismatch %s %s: expected %0h actual %0h", name, field, exp, act);
        errors++;
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errs);
        end
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge core_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
        do begin
            @(negedge core_clk);
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            $display("no Wishbone ack within 8 cycles at address %0d", adr);
            errors++;
        end
        rdat = wb_rsp.dat_r;
        @(posedge core_clk);
        wb_req <= '0;
    endtask

    task automatic check_registers();
        logic [31:0] wval [5];
        logic [31:0] rval;
        int          errs_at_start;
        errs_at_start = errors;
        // Every code written differs from its reset value.
        for (int a = 0; a < 5; a++) begin
            wval[a] = (a == 4) ? 32'd1 : 32'((a % 3) + 1);
            wb_access(1'b1, 3'(a), wval[a], rval);
        end
        for (int a = 0; a < 5; a++) begin
            wb_access(1'b0, 3'(a), 32'd0, rval);
            if (rval !== wval[a]) begin
                mismatch("reg_access", $sformatf("address %0d", a), wval[a], rval);
            end
        end
        wb_access(1'b0, 3'd6, 32'd0, rval);
        if (rval !== 32'd0) begin
            mismatch("reg_access", "address 6", 32'd0, rval);
        end
        for (int a = 0; a < 5; a++) begin
            wb_access(1'b1, 3'(a), 32'd0, rval);
        end
        report_test("reg_access", errors - errs_at_start);
    endtask

    task automatic check_output(input int out, input smartnic_pkg::axis_beat_t got);
        smartnic_pkg::axis_beat_t exp;
        int                       q;
        int                       r;
        int                       errs_before;
        q = out * 4 + int'(got.tid);
        if (open_src[out] >= 0 && open_src[out] != int'(got.tid)) begin
            $display("packets from sources %0d and %0d interleave on %s",
                     open_src[out], got.tid, out_name(out));
            errors++;
        end
        open_src[out] = got.last ? -1 : int'(got.tid);
        if (exp_beats[q].size() == 0) begin
            $display("beat from source %0d on %s where none was expected", got.tid, out_name(out));
            errors++;
        end else begin
            exp = exp_beats[q].pop_front();
            r = exp_rows[q].pop_front();
            errs_before = errors;
            if (got.data !== exp.data) begin
                mismatch(rows[r].name, "data", exp.data, got.data);
            end
            if ({got.keep, got.last, got.tid, got.tdest} !==
                {exp.keep, exp.last, exp.tid, exp.tdest}) begin
                mismatch(rows[r].name, "keep/last/tid/tdest",
                         {exp.keep, exp.last, exp.tid, exp.tdest},
                         {got.keep, got.last, got.tid, got.tdest});
            end
            if (errors != errs_before) begin
                row_errs[r]++;
            end
            row_left[r]--;
            if (row_left[r] == 0) begin
                report_test(rows[r].name, row_errs[r]);
            end
        end
    endtask

    function automatic smartnic_pkg::axis_beat_t random_beat(input logic last);
        smartnic_pkg::axis_beat_t beat;
        for (int w = 0; w < 16; w++) begin
            beat.data[w*32 +: 32] = $urandom;
        end
        beat.keep  = last ? ({64{1'b1}} >> ($urandom % 64)) : {64{1'b1}};
        beat.last  = last;
        // The switch must overwrite whatever the source puts in tid and tdest.
        beat.tid   = 2'($urandom);
        beat.tdest = 2'($urandom);
        return beat;
    endfunction

    function automatic logic source_ready(input int src);
        return (src < NUM_CMAC) ? cmac_ready[src] : host_ready[src - NUM_CMAC];
    endfunction

    task automatic drive_source(input int src, input logic valid,
                                input smartnic_pkg::axis_beat_t beat);
        if (src < NUM_CMAC) begin
            cmac_valid[src] <= valid;
            cmac_beat[src]  <= beat;
        end else begin
            host_valid[src - NUM_CMAC] <= valid;
            host_beat[src - NUM_CMAC]  <= beat;
        end
    endtask

    task automatic send_packet(input int r);
        smartnic_pkg::axis_beat_t beat;
        smartnic_pkg::axis_beat_t exp;
        logic [31:0]              rval;
        int                       q;
        q = ((rows[r].dest == DEST_APP) ? rows[r].src % NUM_CMAC : 2) * 4 + rows[r].src;
        @(posedge core_clk);
        for (int b = 0; b < rows[r].len; b++) begin
            if (b == rows[r].len / 2 && rows[r].mid_code >= 0) begin
                wb_access(1'b1, 3'(rows[r].src), 32'(rows[r].mid_code), rval);
            end
            beat = random_beat(b == rows[r].len - 1);
            exp = beat;
            exp.tid = smartnic_pkg::port_t'(rows[r].src);
            if (rows[r].dest == DEST_APP) begin
                exp.tdest = smartnic_pkg::igr_tdest_t'({1'b0, exp.tid[0]});
            end else begin
                exp.tdest = rows[r].code;
            end
            if (rows[r].dest != DEST_NONE) begin
                exp_beats[q].push_back(exp);
                exp_rows[q].push_back(r);
            end
            drive_source(rows[r].src, 1'b1, beat);
            do begin
                @(negedge core_clk);
            end while (!source_ready(rows[r].src));
            @(posedge core_clk);
            drive_source(rows[r].src, 1'b0, beat);
        end
        if (rows[r].dest == DEST_NONE) begin
            report_test(rows[r].name, row_errs[r]);
        end
    endtask

    task automatic send_source(input int src, input int first, input int last);
        for (int r = first; r < last; r++) begin
            if (rows[r].src == src) begin
                send_packet(r);
            end
        end
    endtask

    function automatic int pending(input bit with_byp);
        int n;
        n = 0;
        for (int q = 0; q < NUM_Q; q++) begin
            if (with_byp || q < 8) begin
                n += exp_beats[q].size();
            end
        end
        return n;
    endfunction

    // Rows of one batch run together, one process per source.
    task automatic run_batch(input int first, input int last);
        logic [31:0] rval;
        bit          coded [4];
        for (int s = 0; s < 4; s++) begin
            coded[s] = 1'b0;
        end
        // A source gets its code once per batch, ahead of its first packet.
        for (int r = first; r < last; r++) begin
            if (!coded[rows[r].src]) begin
                wb_access(1'b1, 3'(rows[r].src), 32'(rows[r].code), rval);
                coded[rows[r].src] = 1'b1;
            end
            row_left[r] = (rows[r].dest == DEST_NONE) ? 0 : rows[r].len;
        end
        if (rows[first].pause != paused) begin
            wb_access(1'b1, smartnic_pkg::REG_ADDR_SWITCH_CONFIG, 32'(rows[first].pause), rval);
            paused = rows[first].pause;
        end
        for (int s = 0; s < 4; s++) begin
            automatic int src = s;
            fork
                send_source(src, first, last);
            join_none
        end
        wait fork;
        // Held bypass packets are only waited for once the pause is lifted.
        while (pending(!paused) != 0) begin
            @(negedge core_clk);
        end
    endtask

    initial begin
        int total;
        int first;
        int last;
        reset  = 1'b1;
        wb_req = '0;
        byp_ready = 1'b0;
        for (int i = 0; i < NUM_CMAC; i++) begin
            cmac_valid[i] = 1'b0;
            cmac_beat[i]  = '0;
            host_valid[i] = 1'b0;
            host_beat[i]  = '0;
            app_ready[i]  = 1'b0;
        end
        for (int o = 0; o < 3; o++) begin
            open_src[o] = -1;
        end
        seed = $urandom(32'h417);

        add_row("app_line0",       0, 4, 2'd0, -1, 1'b0, DEST_APP,  0);
        add_row("app_host0",       2, 5, 2'd1, -1, 1'b0, DEST_APP,  1);
        add_row("app_line1_both",  1, 6, 2'd0, -1, 1'b0, DEST_APP,  2);
        add_row("app_host1_both",  3, 6, 2'd1, -1, 1'b0, DEST_APP,  2);
        add_row("byp_line0",       0, 5, 2'd2, -1, 1'b0, DEST_BYP,  3);
        add_row("byp_host1",       3, 4, 2'd2, -1, 1'b0, DEST_BYP,  3);
        add_row("drop_host0",      2, 4, 2'd3, -1, 1'b0, DEST_NONE, 4);
        add_row("after_drop",      2, 3, 2'd0, -1, 1'b0, DEST_APP,  5);
        add_row("mid_write",       1, 6, 2'd0,  2, 1'b0, DEST_APP,  6);
        add_row("after_mid_write", 1, 3, 2'd2, -1, 1'b0, DEST_BYP,  6);
        add_row("paused_byp_a",    0, 3, 2'd2, -1, 1'b1, DEST_BYP,  7);
        add_row("paused_byp_b",    0, 3, 2'd2, -1, 1'b1, DEST_BYP,  7);
        add_row("app_while_pause", 1, 4, 2'd1, -1, 1'b1, DEST_APP,  7);
        add_row("after_resume",    2, 2, 2'd0, -1, 1'b0, DEST_APP,  8);

        total = 0;
        foreach (rows[r]) begin
            total += rows[r].len;
        end
        limit = 8 * total + 200;

        repeat (4) @(posedge core_clk);
        reset <= 1'b0;
        check_registers();
        first = 0;
        while (first < rows.size()) begin
            last = first;
            while (last < rows.size() && rows[last].batch == rows[first].batch) begin
                last++;
            end
            run_batch(first, last);
            first = last;
        end
        if (tests_run != rows.size() + 1) begin
            $display("only %0d of %0d tests completed", tests_run, rows.size() + 1);
            errors++;
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/smartnic_pkg.sv
hdl/axis_pipe.sv
hdl/igr_tdest_tag.sv
hdl/axis_pkt_arbiter.sv
hdl/igr_path_demux.sv
hdl/smartnic_sw_regs.sv
hdl/smartnic_igr_switch.sv
bench/smartnic_igr_switch_tb.sv
